/* source/decode_pkg.sv */
////////////////////////////////////////
// Decode stage package
// Instruction types, control encodings and RV32 opcodes
////////////////////////////////////////

`default_nettype none

package decode_pkg;

  typedef logic [31:0] instr_t;      // Raw instruction word
  typedef logic [4:0]  reg_addr_t;   // Register file index
  typedef logic [3:0]  credit_cnt_t; // Execute queue credits
  typedef logic [1:0]  lsu_size_t;   // Memory access width

  // Access sizes, same code as funct3[1:0] of loads and stores
  localparam lsu_size_t LSU_BYTE = 2'b00;
  localparam lsu_size_t LSU_HALF = 2'b01;
  localparam lsu_size_t LSU_WORD = 2'b10;

  ////////////////////////////////////////
  // Control field encodings
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU // Branch compares
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,  // rs1
    OP_A_PC,   // Current pc
    OP_A_ZERO  // Constant zero, for LUI
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_sel_e;

  // Order follows funct3 of the M extension
  typedef enum logic [2:0] {
    MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
    MD_DIV, MD_DIVU, MD_REM, MD_REMU
  } muldiv_op_e;

  typedef enum logic [2:0] {
    SYS_NONE, SYS_ECALL, SYS_EBREAK, SYS_MRET, SYS_WFI, SYS_FENCEI
  } sys_op_e;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011; // Shared by RV32I and RV32M
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111; // FENCE, FENCE.I
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

endpackage

`default_nettype wire

/* source/id_ctrl_if.sv */
////////////////////////////////////////
// Decoded control bundle
////////////////////////////////////////

`default_nettype none

interface id_ctrl_if;
  import decode_pkg::*;

  logic       illegal;   // No decoder recognised the word
  logic       alu_en;
  alu_op_e    alu_op;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_sel_e   imm_sel;
  logic       muldiv_en;
  muldiv_op_e muldiv_op;
  logic       lsu_en;
  logic       lsu_we;    // Store when set
  lsu_size_t  lsu_size;
  logic       lsu_sext;  // Sign extend load data
  logic       rf_we;
  sys_op_e    sys_op;

  modport src (output illegal, alu_en, alu_op, op_a_sel, op_b_sel, imm_sel,
               muldiv_en, muldiv_op, lsu_en, lsu_we, lsu_size, lsu_sext, rf_we, sys_op);
  modport snk (input  illegal, alu_en, alu_op, op_a_sel, op_b_sel, imm_sel,
               muldiv_en, muldiv_op, lsu_en, lsu_we, lsu_size, lsu_sext, rf_we, sys_op);

endinterface

`default_nettype wire

/* source/base_decoder.sv */
////////////////////////////////////////
// RV32I base decoder
// Maps opcode, funct3 and funct7 to control fields
////////////////////////////////////////

`default_nettype none

module base_decoder (
  input  decode_pkg::instr_t instr_i,
  id_ctrl_if.src             ctrl
);
  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    illegal        = 1'b0;
    ctrl.alu_en    = 1'b0;
    ctrl.alu_op    = ALU_ADD;
    ctrl.op_a_sel  = OP_A_REG;
    ctrl.op_b_sel  = OP_B_REG;
    ctrl.imm_sel   = IMM_I;
    ctrl.muldiv_en = 1'b0;   // M extension lives in its own decoder
    ctrl.muldiv_op = MD_MUL;
    ctrl.lsu_en    = 1'b0;
    ctrl.lsu_we    = 1'b0;
    ctrl.lsu_size  = LSU_WORD;
    ctrl.lsu_sext  = 1'b0;
    ctrl.rf_we     = 1'b0;
    ctrl.sys_op    = SYS_NONE;

    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        ctrl.alu_en   = 1'b1;
        ctrl.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
        ctrl.rf_we    = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin         // ALU forms pc + offset
        ctrl.alu_en   = 1'b1;
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        ctrl.rf_we    = 1'b1;          // Link register
        if (opcode == OPC_JALR && funct3 != 3'b000) illegal = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.alu_en  = 1'b1;
        ctrl.imm_sel = IMM_B;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = (opcode == OPC_STORE);
        ctrl.rf_we    = (opcode == OPC_LOAD);
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = (opcode == OPC_STORE) ? IMM_S : IMM_I;
        ctrl.lsu_sext = (opcode == OPC_LOAD) && !funct3[2]; // LB, LH
        case (funct3[1:0])
          2'b00:   ctrl.lsu_size = LSU_BYTE;
          2'b01:   ctrl.lsu_size = LSU_HALF;
          2'b10:   ctrl.lsu_size = LSU_WORD;
          default: illegal = 1'b1;
        endcase
        // Unsigned variants exist for loads below word size only
        if (funct3[2] && (opcode == OPC_STORE || funct3[1])) illegal = 1'b1;
      end
      OPC_OP_IMM, OPC_OP: begin
        ctrl.alu_en   = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.op_b_sel = (opcode == OPC_OP_IMM) ? OP_B_IMM : OP_B_REG;
        case (funct3)
          3'b000:  ctrl.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl.alu_op = ALU_SLL;
          3'b010:  ctrl.alu_op = ALU_SLT;
          3'b011:  ctrl.alu_op = ALU_SLTU;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b101:  ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
        // funct7 matters for shifts and every OP; only bit 30 may be set
        if ((opcode == OPC_OP || funct3[1:0] == 2'b01) &&
            (funct7 & 7'b1011111) != 7'b0000000) illegal = 1'b1;
        // Bit 30 only selects SUB and SRA
        if ((opcode == OPC_OP || funct3[1:0] == 2'b01) && funct7[5] &&
            funct3 != 3'b101 && !(opcode == OPC_OP && funct3 == 3'b000))
          illegal = 1'b1;
      end
      OPC_MISC_MEM: begin
        if (funct3 == 3'b001) ctrl.sys_op = SYS_FENCEI;
        else if (funct3 != 3'b000) illegal = 1'b1; // Plain FENCE is a no-op
      end
      OPC_SYSTEM: begin
        if ({instr_i[19:15], funct3, instr_i[11:7]} != 13'd0) begin
          illegal = 1'b1;              // CSR access not supported
        end else begin
          case (instr_i[31:20])
            12'h000: ctrl.sys_op = SYS_ECALL;
            12'h001: ctrl.sys_op = SYS_EBREAK;
            12'h302: ctrl.sys_op = SYS_MRET;
            12'h105: ctrl.sys_op = SYS_WFI;
            default: illegal = 1'b1;
          endcase
        end
      end
      default: illegal = 1'b1;
    endcase

    // Nothing may fire for an unrecognised word
    if (illegal) begin
      ctrl.alu_en = 1'b0;
      ctrl.lsu_en = 1'b0;
      ctrl.lsu_we = 1'b0;
      ctrl.rf_we  = 1'b0;
      ctrl.sys_op = SYS_NONE;
    end
    ctrl.illegal = illegal;
  end

endmodule

`default_nettype wire

/* source/muldiv_decoder.sv */
////////////////////////////////////////
// RV32M multiply and divide decoder
////////////////////////////////////////

`default_nettype none

module muldiv_decoder (
  input  decode_pkg::instr_t instr_i,
  id_ctrl_if.src             ctrl
);
  import decode_pkg::*;

  logic match;

  assign match = (instr_i[6:0] == OPC_OP) && (instr_i[31:25] == 7'b0000001);

  always_comb begin
    ctrl.illegal   = !match;
    ctrl.alu_en    = 1'b0;
    ctrl.alu_op    = ALU_ADD;
    ctrl.op_a_sel  = OP_A_REG;
    ctrl.op_b_sel  = OP_B_REG;
    ctrl.imm_sel   = IMM_I;
    ctrl.muldiv_en = match;
    ctrl.muldiv_op = muldiv_op_e'(instr_i[14:12]); // funct3 is the op code
    ctrl.lsu_en    = 1'b0;
    ctrl.lsu_we    = 1'b0;
    ctrl.lsu_size  = LSU_WORD;
    ctrl.lsu_sext  = 1'b0;
    ctrl.rf_we     = match;
    ctrl.sys_op    = SYS_NONE;
  end

endmodule

`default_nettype wire

/* source/decoder.sv */
////////////////////////////////////////
// Instruction decoder
// Priority merge of sub-decoders, illegal and kill handling
////////////////////////////////////////

`default_nettype none

module decoder #(
  parameter bit M_EXT = 1'b1
) (
  input  decode_pkg::instr_t instr_i,
  input  logic               illegal_c_insn_i, // Bad compressed encoding from fetch
  input  logic               kill_i,           // Exception already taken in fetch
  id_ctrl_if.src             ctrl
);
  import decode_pkg::*;

  logic md_hit;  // M decoder wins
  logic hit;     // Some decoder matched
  logic live;    // Enables survive

  id_ctrl_if base_ctrl ();
  id_ctrl_if md_ctrl ();

  base_decoder base_decoder_i (.instr_i(instr_i), .ctrl(base_ctrl.src));

  if (M_EXT) begin : g_muldiv
    muldiv_decoder muldiv_decoder_i (.instr_i(instr_i), .ctrl(md_ctrl.src));
  end else begin : g_no_muldiv
    // Looks like a decoder that never matches
    assign md_ctrl.illegal   = 1'b1;
    assign md_ctrl.alu_en    = 1'b0;
    assign md_ctrl.alu_op    = ALU_ADD;
    assign md_ctrl.op_a_sel  = OP_A_REG;
    assign md_ctrl.op_b_sel  = OP_B_REG;
    assign md_ctrl.imm_sel   = IMM_I;
    assign md_ctrl.muldiv_en = 1'b0;
    assign md_ctrl.muldiv_op = MD_MUL;
    assign md_ctrl.lsu_en    = 1'b0;
    assign md_ctrl.lsu_we    = 1'b0;
    assign md_ctrl.lsu_size  = LSU_WORD;
    assign md_ctrl.lsu_sext  = 1'b0;
    assign md_ctrl.rf_we     = 1'b0;
    assign md_ctrl.sys_op    = SYS_NONE;
  end

  assign md_hit = !illegal_c_insn_i && !md_ctrl.illegal;
  assign hit    = md_hit || (!illegal_c_insn_i && !base_ctrl.illegal);
  assign live   = hit && !kill_i;

  ////////////////////////////////////////
  // Merge, no match gives the idle field values
  ////////////////////////////////////////

  assign ctrl.illegal   = !hit && !kill_i; // Kill hides illegal too
  assign ctrl.alu_en    = live && (md_hit ? md_ctrl.alu_en    : base_ctrl.alu_en);
  assign ctrl.muldiv_en = live && (md_hit ? md_ctrl.muldiv_en : base_ctrl.muldiv_en);
  assign ctrl.lsu_en    = live && (md_hit ? md_ctrl.lsu_en    : base_ctrl.lsu_en);
  assign ctrl.lsu_we    = live && (md_hit ? md_ctrl.lsu_we    : base_ctrl.lsu_we);
  assign ctrl.rf_we     = live && (md_hit ? md_ctrl.rf_we     : base_ctrl.rf_we);
  assign ctrl.sys_op    = !live ? SYS_NONE : (md_hit ? md_ctrl.sys_op : base_ctrl.sys_op);

  // Operand and size fields ignore kill
  assign ctrl.alu_op    = !hit ? ALU_ADD  : (md_hit ? md_ctrl.alu_op    : base_ctrl.alu_op);
  assign ctrl.op_a_sel  = !hit ? OP_A_REG : (md_hit ? md_ctrl.op_a_sel  : base_ctrl.op_a_sel);
  assign ctrl.op_b_sel  = !hit ? OP_B_REG : (md_hit ? md_ctrl.op_b_sel  : base_ctrl.op_b_sel);
  assign ctrl.imm_sel   = !hit ? IMM_I    : (md_hit ? md_ctrl.imm_sel   : base_ctrl.imm_sel);
  assign ctrl.muldiv_op = !hit ? MD_MUL   : (md_hit ? md_ctrl.muldiv_op : base_ctrl.muldiv_op);
  assign ctrl.lsu_size  = !hit ? LSU_WORD : (md_hit ? md_ctrl.lsu_size  : base_ctrl.lsu_size);
  assign ctrl.lsu_sext  = hit && (md_hit ? md_ctrl.lsu_sext : base_ctrl.lsu_sext);

endmodule

`default_nettype wire

/* source/id_ex_pipe.sv */
////////////////////////////////////////
// ID to EX register
// Credit counter gates fetch against the execute queue
////////////////////////////////////////

`default_nettype none

module id_ex_pipe #(
  parameter int EX_CREDITS = 4   // Execute queue depth, 1 to 15
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   instr_valid_i,
  output logic                   instr_ready_o,
  input  decode_pkg::reg_addr_t  rs1_i,
  input  decode_pkg::reg_addr_t  rs2_i,
  input  decode_pkg::reg_addr_t  rd_i,
  id_ctrl_if.snk                 ctrl,
  input  logic                   credit_return_i, // One pulse per freed slot
  output logic                   ex_valid_o,
  output decode_pkg::reg_addr_t  ex_rs1_o,
  output decode_pkg::reg_addr_t  ex_rs2_o,
  output decode_pkg::reg_addr_t  ex_rd_o,
  output logic                   ex_illegal_o,
  output logic                   ex_alu_en_o,
  output decode_pkg::alu_op_e    ex_alu_op_o,
  output decode_pkg::op_a_sel_e  ex_op_a_sel_o,
  output decode_pkg::op_b_sel_e  ex_op_b_sel_o,
  output decode_pkg::imm_sel_e   ex_imm_sel_o,
  output logic                   ex_muldiv_en_o,
  output decode_pkg::muldiv_op_e ex_muldiv_op_o,
  output logic                   ex_lsu_en_o,
  output logic                   ex_lsu_we_o,
  output decode_pkg::lsu_size_t  ex_lsu_size_o,
  output logic                   ex_lsu_sext_o,
  output logic                   ex_rf_we_o,
  output decode_pkg::sys_op_e    ex_sys_op_o
);
  import decode_pkg::*;

  credit_cnt_t credit_cnt;  // Free slots in execute
  logic        accept;

  assign instr_ready_o = (credit_cnt != '0);
  assign accept        = instr_valid_i && instr_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      credit_cnt <= credit_cnt_t'(EX_CREDITS);
    end else if (accept && !credit_return_i) begin
      credit_cnt <= credit_cnt - credit_cnt_t'(1);  // Slot taken
    end else if (!accept && credit_return_i) begin
      credit_cnt <= credit_cnt + credit_cnt_t'(1);  // Slot freed
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) ex_valid_o <= 1'b0;
    else       ex_valid_o <= accept; // One cycle per accept
  end

  // Payload, qualified by ex_valid_o
  always_ff @(posedge clk) begin
    if (accept) begin
      ex_rs1_o       <= rs1_i;
      ex_rs2_o       <= rs2_i;
      ex_rd_o        <= rd_i;
      ex_illegal_o   <= ctrl.illegal;
      ex_alu_en_o    <= ctrl.alu_en;
      ex_alu_op_o    <= ctrl.alu_op;
      ex_op_a_sel_o  <= ctrl.op_a_sel;
      ex_op_b_sel_o  <= ctrl.op_b_sel;
      ex_imm_sel_o   <= ctrl.imm_sel;
      ex_muldiv_en_o <= ctrl.muldiv_en;
      ex_muldiv_op_o <= ctrl.muldiv_op;
      ex_lsu_en_o    <= ctrl.lsu_en;
      ex_lsu_we_o    <= ctrl.lsu_we;
      ex_lsu_size_o  <= ctrl.lsu_size;
      ex_lsu_sext_o  <= ctrl.lsu_sext;
      ex_rf_we_o     <= ctrl.rf_we;
      ex_sys_op_o    <= ctrl.sys_op;
    end
  end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
////////////////////////////////////////
// Decode stage top
// Decoder followed by the credited ID/EX register
////////////////////////////////////////

`default_nettype none

module decode_stage #(
  parameter bit M_EXT      = 1'b1,
  parameter int EX_CREDITS = 4
) (
  input  logic                   clk,
  input  logic                   rst_i,
  // Fetch side
  input  logic                   instr_valid_i,
  input  decode_pkg::instr_t     instr_i,
  input  logic                   illegal_c_insn_i,
  input  logic                   kill_i,
  output logic                   instr_ready_o,
  // Execute side
  input  logic                   credit_return_i,
  output logic                   ex_valid_o,
  output decode_pkg::reg_addr_t  ex_rs1_o,
  output decode_pkg::reg_addr_t  ex_rs2_o,
  output decode_pkg::reg_addr_t  ex_rd_o,
  output logic                   ex_illegal_o,
  output logic                   ex_alu_en_o,
  output decode_pkg::alu_op_e    ex_alu_op_o,
  output decode_pkg::op_a_sel_e  ex_op_a_sel_o,
  output decode_pkg::op_b_sel_e  ex_op_b_sel_o,
  output decode_pkg::imm_sel_e   ex_imm_sel_o,
  output logic                   ex_muldiv_en_o,
  output decode_pkg::muldiv_op_e ex_muldiv_op_o,
  output logic                   ex_lsu_en_o,
  output logic                   ex_lsu_we_o,
  output decode_pkg::lsu_size_t  ex_lsu_size_o,
  output logic                   ex_lsu_sext_o,
  output logic                   ex_rf_we_o,
  output decode_pkg::sys_op_e    ex_sys_op_o
);

  id_ctrl_if id_ctrl ();  // Merged decode result

  decoder #(
    .M_EXT (M_EXT)
  ) decoder_i (
    .instr_i          (instr_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .kill_i           (kill_i),
    .ctrl             (id_ctrl.src)
  );

  // Register indices come straight from the word, ex_ ports match by name
  id_ex_pipe #(
    .EX_CREDITS (EX_CREDITS)
  ) id_ex_pipe_i (
    .rs1_i (instr_i[19:15]),
    .rs2_i (instr_i[24:20]),
    .rd_i  (instr_i[11:7]),
    .ctrl  (id_ctrl.snk),
    .*
  );

endmodule

`default_nettype wire

/* dv/tb_decode_stage.sv */
////////////////////////////////////////
// Decode stage testbench
// Random and directed decode, credit flow checks
////////////////////////////////////////

`default_nettype none

module tb_decode_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import decode_pkg::*;

  localparam int EX_CREDITS = 4;
  localparam int N_RANDOM   = 400;

  logic clk, rst_i, instr_valid_i, illegal_c_insn_i, kill_i, credit_return_i;
  logic instr_ready_o, ex_valid_o, ex_illegal_o, ex_alu_en_o, ex_muldiv_en_o;
  logic ex_lsu_en_o, ex_lsu_we_o, ex_lsu_sext_o, ex_rf_we_o;
  instr_t     instr_i;
  reg_addr_t  ex_rs1_o, ex_rs2_o, ex_rd_o;
  alu_op_e    ex_alu_op_o;
  op_a_sel_e  ex_op_a_sel_o;
  op_b_sel_e  ex_op_b_sel_o;
  imm_sel_e   ex_imm_sel_o;
  muldiv_op_e ex_muldiv_op_o;
  lsu_size_t  ex_lsu_size_o;
  sys_op_e    ex_sys_op_o;

  integer      seed;
  string       test_name;
  logic [39:0] exp_q[$];   // Expected fields per accept
  logic [39:0] mask_q[$];  // Fields that matter
  string       name_q[$];
  int          due_q[$];   // Cycle at which a credit goes back
  int          cyc;
  int          outstanding;
  int          hold_cnt;
  bit          hold_credits;
  bit          acc_last;   // Accept seen at the last rising edge

  decode_stage decode_stage_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // Reference decode
  ////////////////////////////////////////

  // Layout {rs1,rs2,rd,ill,alu,md,lsu,we,rf,sys,aop,opa,opb,imm,mdop,size,sext}
  function automatic logic [39:0] ref_decode(input logic [31:0] w, input logic c,
                                             input logic k, output logic [39:0] m);
    logic [6:0] opc, f7;
    logic [2:0] f3, sys, imm, mdop;
    logic [3:0] aop;
    logic [1:0] opa, size;
    logic       ill, alu, md, lsu, we, rf, opb, sext;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    {ill, alu, md, lsu, we, rf, opb, sext} = '0;
    sys  = SYS_NONE;
    aop  = ALU_ADD;
    opa  = OP_A_REG;
    imm  = IMM_I;
    mdop = f3;
    size = f3[1:0];
    case (opc)
      OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: begin
        {alu, rf, opb} = 3'b111;
        opa = (opc == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        imm = (opc == OPC_JAL) ? IMM_J : (opc == OPC_JALR) ? IMM_I : IMM_U;
        ill = (opc == OPC_JALR) && (f3 != 3'd0);
      end
      OPC_BRANCH: begin
        alu = 1'b1;
        imm = IMM_B;
        ill = (f3 == 3'b010) || (f3 == 3'b011);
        aop = (f3 == 3'd0) ? ALU_EQ : (f3 == 3'd1) ? ALU_NE : (f3 == 3'd4) ? ALU_LT :
              (f3 == 3'd5) ? ALU_GE : (f3 == 3'd6) ? ALU_LTU : ALU_GEU;
      end
      OPC_LOAD, OPC_STORE: begin
        lsu  = 1'b1;
        we   = (opc == OPC_STORE);
        rf   = !we;
        sext = !we && !f3[2];            // LB and LH only
        ill  = (f3[1:0] == 2'b11) || (f3[2] && (we || f3[1]));
      end
      OPC_OP_IMM, OPC_OP: begin
        alu = 1'b1;
        rf  = 1'b1;
        opb = (opc == OPC_OP_IMM);
        case (f3)
          3'd0: aop = (opc == OPC_OP && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
          3'd1: aop = ALU_SLL;
          3'd2: aop = ALU_SLT;
          3'd3: aop = ALU_SLTU;
          3'd4: aop = ALU_XOR;
          3'd5: aop = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
          3'd6: aop = ALU_OR;
          default: aop = ALU_AND;
        endcase
        if (opc == OPC_OP && f7 == 7'h01) begin
          {alu, md} = 2'b01;             // RV32M wins
        end else if (opc == OPC_OP || f3 == 3'd1 || f3 == 3'd5) begin
          ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd5 || opc == OPC_OP && f3 == 3'd0)));
        end
      end
      OPC_MISC_MEM: begin
        ill = (f3 > 3'd1);
        if (f3 == 3'd1) sys = SYS_FENCEI;
      end
      OPC_SYSTEM: begin
        ill = 1'b0;
        if (w[19:7] != 13'd0) ill = 1'b1;
        else if (w[31:20] == 12'h000) sys = SYS_ECALL;
        else if (w[31:20] == 12'h001) sys = SYS_EBREAK;
        else if (w[31:20] == 12'h302) sys = SYS_MRET;
        else if (w[31:20] == 12'h105) sys = SYS_WFI;
        else ill = 1'b1;
      end
      default: ill = 1'b1;
    endcase
    ill = ill || c;                      // Bad compressed word
    if (ill || k) begin
      {alu, md, lsu, we, rf} = '0;
      sys = SYS_NONE;
    end
    if (k) ill = 1'b0;                   // Kill hides illegal
    m = {{24{1'b1}}, {10{alu}}, {3{md}}, {3{lsu}}};
    return {w[19:15], w[24:20], w[11:7], ill, alu, md, lsu, we, rf, sys,
            aop, opa, opb, imm, mdop, size, sext};
  endfunction

  ////////////////////////////////////////
  // Monitor, execute model and checker
  ////////////////////////////////////////

  always @(posedge clk) begin
    logic [39:0] e, m;
    acc_last = 1'b0;
    if (rst_i) begin
      outstanding = 0;
    end else begin
      if (instr_valid_i && instr_ready_o) begin
        e = ref_decode(instr_i, illegal_c_insn_i, kill_i, m);
        exp_q.push_back(e);
        mask_q.push_back(m);
        name_q.push_back(test_name);
        outstanding++;
        acc_last = 1'b1;
        if (hold_credits) hold_cnt++;
      end
      if (credit_return_i) outstanding--;
      assert (outstanding <= EX_CREDITS)
        else fail("Execute queue overflow, more instructions than credits");
    end
  end

  always @(negedge clk) begin
    logic [39:0] act, e, m;
    string nm;
    cyc++;
    if (rst_i) begin
      due_q.delete();
      credit_return_i = 1'b0;
    end else begin
      assert (ex_valid_o == acc_last)
        else fail("ex_valid_o does not follow the accept by exactly one cycle");
      if (ex_valid_o) begin
        e  = exp_q.pop_front();
        m  = mask_q.pop_front();
        nm = name_q.pop_front();
        act = {ex_rs1_o, ex_rs2_o, ex_rd_o, ex_illegal_o, ex_alu_en_o, ex_muldiv_en_o,
               ex_lsu_en_o, ex_lsu_we_o, ex_rf_we_o, ex_sys_op_o, ex_alu_op_o,
               ex_op_a_sel_o, ex_op_b_sel_o, ex_imm_sel_o, ex_muldiv_op_o,
               ex_lsu_size_o, ex_lsu_sext_o};
        assert (((act ^ e) & m) == '0)
          else fail($sformatf("ERROR %s: expected %h actual %h", nm, e & m, act & m));
        due_q.push_back(cyc + $unsigned($random(seed)) % 6);
      end
      credit_return_i = 1'b0;            // One credit per cycle at most
      if (!hold_credits && due_q.size() != 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        credit_return_i = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Present one word and wait until the DUT takes it
  task automatic send(input logic [31:0] w, input logic c, input logic k);
    int t;
    instr_valid_i    = 1'b1;
    instr_i          = w;
    illegal_c_insn_i = c;
    kill_i           = k;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 50) fail("Timeout waiting for the DUT to accept an instruction");
    end while (!acc_last);
  endtask

  task automatic random_word(output logic [31:0] w);
    logic [6:0] opcs[11];
    int sel;
    opcs = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE,
             OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM};
    w   = $random(seed);
    sel = $unsigned($random(seed)) % 13;
    if (sel < 11) w[6:0] = opcs[sel];    // 11 keeps a random opcode
    case ($unsigned($random(seed)) % 4)
      0: w[31:25] = 7'h00;
      1: w[31:25] = 7'h20;
      2: w[31:25] = 7'h01;
      default: ;
    endcase
    if (sel == 12) begin                 // System word with a zero body
      w = 32'h73;
      case ($unsigned($random(seed)) % 5)
        0: w[31:20] = 12'h001;
        1: w[31:20] = 12'h302;
        2: w[31:20] = 12'h105;
        3: w[31:20] = 12'($random(seed));
        default: ;
      endcase
    end
  endtask

  initial begin
    logic [31:0] w;
    int t;
    seed = 88;
    {instr_valid_i, illegal_c_insn_i, kill_i, credit_return_i, hold_credits} = '0;
    instr_i = '0;
    cyc = 0;
    hold_cnt = 0;
    rst_i = 1'b1;
    test_name = "reset";
    repeat (5) @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);
    assert (!ex_valid_o && instr_ready_o)
      else fail("After reset ex_valid_o is not low or instr_ready_o is not high");

    test_name = "system";
    send(32'h00000073, 0, 0);            // ECALL
    send(32'h00100073, 0, 0);            // EBREAK
    send(32'h30200073, 0, 0);            // MRET
    send(32'h10500073, 0, 0);            // WFI
    send(32'h0000100f, 0, 0);            // FENCE.I
    send(32'h00100073, 0, 1);            // Killed EBREAK

    test_name = "random";
    for (int i = 0; i < N_RANDOM; i++) begin
      random_word(w);
      send(w, ($unsigned($random(seed)) % 12) == 0, ($unsigned($random(seed)) % 10) == 0);
    end
    instr_valid_i = 1'b0;

    // Execute withholds credits until fetch stalls
    test_name = "credit";
    t = 0;
    while (outstanding != 0) begin
      @(negedge clk);
      t++;
      if (t > 100) fail("Timeout waiting for credits to drain");
    end
    hold_credits = 1'b1;
    hold_cnt = 0;
    random_word(w);
    instr_valid_i = 1'b1;
    instr_i = w;
    t = 0;
    while (instr_ready_o) begin
      @(negedge clk);
      t++;
      if (t > 20) fail("Timeout waiting for instr_ready_o to fall");
    end
    assert (hold_cnt == EX_CREDITS)
      else fail($sformatf("ERROR %s: expected %0d actual %0d", test_name, EX_CREDITS, hold_cnt));
    hold_credits = 1'b0;
    t = 0;
    while (!instr_ready_o) begin
      @(negedge clk);
      t++;
      if (t > 20) fail("Timeout waiting for acceptance to resume");
    end
    for (int i = 0; i < 20; i++) begin
      random_word(w);
      send(w, 0, 0);
    end
    instr_valid_i = 1'b0;

    t = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > 50) fail("Timeout waiting for outstanding outputs");
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* decode_stage.f */
source/decode_pkg.sv
source/id_ctrl_if.sv
source/base_decoder.sv
source/muldiv_decoder.sv
source/decoder.sv
source/id_ex_pipe.sv
source/decode_stage.sv
dv/tb_decode_stage.sv

/* Makefile */
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FLIST     ?= decode_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
